//--- filelist.f
+incdir+hw
hw/cic_pkg.sv
hw/cic_credit_fifo.sv
hw/cic_pin_io.sv
hw/cic_bus_ctrl.sv
hw/cic_top.sv
tb/cic_checker.sv
tb/cic_monitor.sv
tb/cic_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for a failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module cic_tb -f filelist.f \
    --Mdir obj_dir -o sim_cic \
    && ./obj_dir/sim_cic > sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

//--- tb/cic_tb.sv
`timescale 1ns/1ps
`include "cic_config.svh"

module cic_tb;
    import cic_pkg::*;

    localparam int N_RAM  = 40;
    localparam int N_REG  = 24;
    localparam int N_PIN  = 8;
    localparam int N_DRV  = 12;
    localparam int N_FLOW = 60;
    localparam int TOTAL  = N_RAM + N_REG + N_PIN + N_DRV + N_FLOW;
    localparam int LIMIT  = 4 * TOTAL + 2000;

    logic          clk = 1'b0;
    logic          i_rst_n;
    logic          i_req_valid;
    cic_bus_req_t  i_req;
    logic          o_req_credit;
    logic          o_rsp_valid;
    cic_bus_rsp_t  o_rsp;
    logic          i_rsp_credit;
    cic_settings_t i_settings;
    logic          i_n64_reset;
    logic          i_cic_clk;
    logic          i_cic_dq;
    logic          o_cic_dq_oe;
    logic          o_invalid_region;
    logic          end_check;
    int            errors;
    int            checked;

    integer     seed = 81;
    int         sent = 0;
    int         credits_back = 0;
    int         granted = 0;
    int         rsp_seen = 0;
    int         rsp_window = 2;  // Response credits the host may have outstanding
    int         grant_rate = 3;  // Grant chance in quarters
    int         cycles = 0;
    int         last_err = 0;
    int         tests_run = 0;
    logic       written [`CIC_RAM_WORDS];
    logic [8:0] wq [$];          // Words that hold defined data

    cic_top u_cic_top (.*);

    cic_monitor u_monitor (
        .clk (clk), .i_rst_n (i_rst_n), .i_req_valid (i_req_valid), .i_req (i_req),
        .i_req_credit (o_req_credit), .i_rsp_valid (o_rsp_valid), .i_rsp (o_rsp),
        .i_settings (i_settings), .i_n64_reset (i_n64_reset), .i_cic_clk (i_cic_clk),
        .i_cic_dq (i_cic_dq), .i_dq_oe (o_cic_dq_oe), .i_invalid_region (o_invalid_region),
        .i_end_check (end_check), .o_errors (errors), .o_checked (checked)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (o_req_credit) credits_back++;
        if (o_rsp_valid) rsp_seen++;
        if (cycles >= LIMIT) begin
            $display("Timeout: traffic did not drain within %0d cycles", LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Host side response credits, sometimes held back
    always @(negedge clk) begin
        if (i_rst_n && granted - rsp_seen < rsp_window && ($random(seed) & 3) < grant_rate) begin
            i_rsp_credit = 1'b1;
            granted++;
        end else begin
            i_rsp_credit = 1'b0;
        end
    end

    ////////////////////////////////////////
    // Host tasks
    ////////////////////////////////////////

    task automatic send(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                        input logic [3:0] mask);
        while (`CIC_REQ_DEPTH + credits_back - sent <= 0) @(negedge clk);
        i_req       = '{addr: addr, wdata: data, mask: mask, write: wr};
        i_req_valid = 1'b1;
        sent++;
        @(negedge clk);
        i_req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (rsp_seen != sent) @(negedge clk);
    endtask

    task automatic ram_op(input logic do_write);
        logic [8:0] idx;
        if (do_write || wq.size() == 0) begin
            idx = 9'($random(seed));
            send(1'b1, {2'b10, 19'($random(seed)), idx, 2'b00}, 32'($random(seed)),
                 written[idx] ? 4'($random(seed)) : 4'hf);  // First write defines every byte
            if (!written[idx]) wq.push_back(idx);
            written[idx] = 1'b1;
        end else begin
            idx = wq[{$random(seed)} % wq.size()];
            send(1'b0, {2'b10, 19'($random(seed)), idx, 2'b00}, 32'($random(seed)),
                 4'($random(seed)));
        end
    endtask

    task automatic reg_op(input logic wr, input logic [1:0] rid, input logic [31:0] data);
        send(wr, {2'b11, 26'($random(seed)), rid, 2'b00}, data, 4'hf);
    endtask

    // Pins move only with the port idle, then settle through the synchronizers
    task automatic set_pins();
        wait_idle();
        {i_n64_reset, i_cic_clk, i_cic_dq} = 3'($random(seed));
        repeat (4) @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int n);
        wait_idle();
        @(negedge clk);
        $display("test %s: %0d requests, %0d errors", name, n, errors - last_err);
        last_err = errors;
        tests_run++;
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_req_valid  = 1'b0;
        i_req        = '0;
        i_rsp_credit = 1'b0;
        i_settings   = cic_settings_t'(59'({$random(seed), $random(seed)}));
        i_n64_reset  = 1'b1;
        i_cic_clk    = 1'b0;
        i_cic_dq     = 1'b1;
        end_check    = 1'b0;
        foreach (written[i]) written[i] = 1'b0;
        repeat (8) @(negedge clk);
        i_rst_n = 1'b1;

        ram_op(1'b1);
        for (int i = 1; i < N_RAM; i++) ram_op(($random(seed) & 1) != 0);
        finish_test("ram", N_RAM);

        i_settings = cic_settings_t'(59'({$random(seed), $random(seed)}));
        for (int i = 0; i < N_REG; i++) begin
            case ($random(seed) & 3)
                0: reg_op(1'b0, 2'($random(seed) & 1), '0);
                1: reg_op(1'b0, 2'd3, '0);
                2: send(1'b0, {1'b0, 31'($random(seed))}, '0, 4'hf);
                default: send(1'b1, {1'b0, 31'($random(seed))}, 32'($random(seed)), 4'hf);
            endcase
        end
        finish_test("registers", N_REG);

        for (int i = 0; i < N_PIN; i++) begin
            set_pins();
            reg_op(1'b0, 2'd2, '0);
        end
        finish_test("pin readback", N_PIN);

        for (int i = 0; i < N_DRV; i++) begin
            set_pins();
            reg_op(1'b1, 2'd2, 32'($random(seed)));
        end
        finish_test("pin drive", N_DRV);

        rsp_window = 1;
        grant_rate = 1;
        for (int i = 0; i < N_FLOW; i++) begin
            if (($random(seed) & 3) == 0) reg_op(1'b0, 2'($random(seed) & 1), '0);
            else ram_op(($random(seed) & 1) != 0);
        end
        finish_test("flow control", N_FLOW);

        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        @(negedge clk);
        $display("tests %0d, requests %0d, responses checked %0d, errors %0d",
                 tests_run, sent, checked, errors);
        if (errors == 0 && checked == TOTAL) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb/cic_monitor.sv
`timescale 1ns/1ps
`include "cic_config.svh"

module cic_monitor (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_req_valid,
    input  cic_pkg::cic_bus_req_t  i_req,
    input  logic                   i_req_credit,
    input  logic                   i_rsp_valid,
    input  cic_pkg::cic_bus_rsp_t  i_rsp,
    input  cic_pkg::cic_settings_t i_settings,
    input  logic                   i_n64_reset,
    input  logic                   i_cic_clk,
    input  logic                   i_cic_dq,
    input  logic                   i_dq_oe,
    input  logic                   i_invalid_region,
    input  logic                   i_end_check,
    output int                     o_errors,
    output int                     o_checked
);
    import cic_pkg::*;

    logic [31:0] mem [`CIC_RAM_WORDS];  // Model of the firmware RAM
    logic [31:0] exp_data [$];
    logic        exp_wr [$];
    logic        exp_pin [$];           // Response belongs to a data-pin write
    logic        exp_oe [$];
    int          req_seen = 0;
    int          credits_back = 0;
    int          pulses = 0;
    int          pulses_exp = 0;
    int          errors = 0;
    int          checked = 0;

    assign o_errors  = errors;
    assign o_checked = checked;

    ////////////////////////////////////////
    // The model runs on the request side
    ////////////////////////////////////////

    always @(posedge clk) begin : watch_req
        logic [31:0] rd;
        logic [8:0]  idx;
        logic        pin;
        logic        oe;
        if (i_rst_n && i_req_valid) begin
            idx = i_req.addr[10:2];
            rd  = '0;
            pin = 1'b0;
            oe  = 1'b0;
            if (req_seen >= `CIC_REQ_DEPTH + credits_back) begin
                $display("Host sent a request without holding a credit at %0t", $time);
                errors++;
            end
            req_seen++;
            if (i_req.write) begin
                if (i_req.addr[31:30] == 2'b10) begin
                    for (int b = 0; b < 4; b++) begin
                        if (i_req.mask[b]) mem[idx][8*b +: 8] = i_req.wdata[8*b +: 8];
                    end
                end else if (i_req.addr[31:30] == 2'b11 && i_req.addr[3:2] == 2'd2) begin
                    pin = 1'b1;
                    oe  = !i_req.wdata[0] && i_n64_reset;  // Console reset wins
                    if (i_req.wdata[3]) pulses_exp++;
                end
            end else if (i_req.addr[31:30] == 2'b10) begin
                rd = mem[idx];
            end else if (i_req.addr[31:30] == 2'b11) begin
                case (i_req.addr[3:2])
                    2'd0: rd = {5'd0, i_settings.disabled, i_settings.mode_64dd,
                                i_settings.region, i_settings.seed,
                                i_settings.checksum[47:32]};
                    2'd1: rd = i_settings.checksum[31:0];
                    2'd2: rd = {29'd0, i_n64_reset, i_cic_clk, i_cic_dq};
                    default: rd = '0;
                endcase
            end
            exp_data.push_back(rd);
            exp_wr.push_back(i_req.write);
            exp_pin.push_back(pin);
            exp_oe.push_back(oe);
        end
        if (i_rst_n && i_req_credit) begin
            // Host credits stay at or below the FIFO depth
            if (credits_back >= req_seen) begin
                $display("Request credit returned at %0t with no request taken", $time);
                errors++;
            end
            credits_back++;
        end
        if (i_rst_n && i_invalid_region) pulses++;
    end

    ////////////////////////////////////////
    // Response side
    ////////////////////////////////////////

    always @(posedge clk) begin : watch_rsp
        logic [31:0] rd;
        logic        wr;
        logic        pin;
        logic        oe;
        if (i_rst_n && i_rsp_valid) begin
            if (exp_data.size() == 0) begin
                $display("Response at %0t with no request outstanding", $time);
                errors++;
            end else begin
                rd  = exp_data.pop_front();
                wr  = exp_wr.pop_front();
                pin = exp_pin.pop_front();
                oe  = exp_oe.pop_front();
                checked++;
                if (i_rsp.rdata !== rd || i_rsp.write !== wr) begin
                    $display("ERR %0t: response %h/%b, expected %h/%b",
                             $time, i_rsp.rdata, i_rsp.write, rd, wr);
                    errors++;
                end
                if (pin && i_dq_oe !== oe) begin
                    $display("ERR %0t: data pin enable %b, expected %b", $time, i_dq_oe, oe);
                    errors++;
                end
            end
        end
        if (i_end_check) begin
            if (pulses != pulses_exp) begin
                $display("ERR %0t: %0d invalid-region pulses, expected %0d",
                         $time, pulses, pulses_exp);
                errors++;
            end
            if (credits_back != req_seen) begin
                $display("ERR %0t: %0d request credits returned, expected %0d",
                         $time, credits_back, req_seen);
                errors++;
            end
        end
    end

endmodule

//--- tb/cic_checker.sv
`timescale 1ns/1ps

module cic_checker (
    input logic clk,
    input logic i_rst_n,
    input logic i_rsp_credit,
    input logic i_rsp_valid,
    input logic i_dq_oe,
    input logic i_invalid_region
);

    int granted;  // Response credits handed out by the host
    int used;     // Responses sent against them

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            granted <= 0;
            used    <= 0;
        end else begin
            granted <= granted + int'(i_rsp_credit);
            used    <= used + int'(i_rsp_valid);
        end
    end

    a_rsp_credit: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rsp_valid |-> (used < granted))
        else $error("response sent without a credit");

    // Line must float while the cartridge itself is in reset
    a_dq_reset: assert property (@(posedge clk) !i_rst_n |-> !i_dq_oe)
        else $error("data pin driven during reset");

    a_pulse_width: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_invalid_region |=> !i_invalid_region)
        else $error("invalid-region pulse longer than one cycle");

endmodule

bind cic_top cic_checker u_checker (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_rsp_credit     (i_rsp_credit),
    .i_rsp_valid      (o_rsp_valid),
    .i_dq_oe          (o_cic_dq_oe),
    .i_invalid_region (o_invalid_region)
);

//--- hw/cic_top.sv
`timescale 1ns/1ps
`include "cic_config.svh"

module cic_top (
    input  logic                   clk,
    input  logic                   i_rst_n,

    // Firmware port
    input  logic                   i_req_valid,
    input  cic_pkg::cic_bus_req_t  i_req,
    output logic                   o_req_credit,
    output logic                   o_rsp_valid,
    output cic_pkg::cic_bus_rsp_t  o_rsp,
    input  logic                   i_rsp_credit,

    // Cartridge settings and console lockout pins
    input  cic_pkg::cic_settings_t i_settings,
    input  logic                   i_n64_reset,
    input  logic                   i_cic_clk,
    input  logic                   i_cic_dq,
    output logic                   o_cic_dq_oe,
    output logic                   o_invalid_region
);
    import cic_pkg::*;

    logic         ctrl_req_valid;
    cic_bus_req_t ctrl_req;
    logic         ctrl_req_credit;
    logic         ctrl_rsp_push;
    cic_bus_rsp_t ctrl_rsp;
    logic         ctrl_rsp_credit;
    logic         dq_we;
    logic         dq_bit;
    cic_pins_t    pins;

    ////////////////////////////////////////
    // Firmware port buffering
    ////////////////////////////////////////

    cic_credit_fifo #(
        .T     (cic_bus_req_t),
        .DEPTH (`CIC_REQ_DEPTH)
    ) u_req_fifo (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_push        (i_req_valid),
        .i_data        (i_req),
        .o_up_credit   (o_req_credit),
        .i_down_credit (ctrl_req_credit),
        .o_valid       (ctrl_req_valid),
        .o_data        (ctrl_req)
    );

    cic_credit_fifo #(
        .T     (cic_bus_rsp_t),
        .DEPTH (`CIC_RSP_DEPTH)
    ) u_rsp_fifo (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_push        (ctrl_rsp_push),
        .i_data        (ctrl_rsp),
        .o_up_credit   (ctrl_rsp_credit),
        .i_down_credit (i_rsp_credit),
        .o_valid       (o_rsp_valid),
        .o_data        (o_rsp)
    );

    ////////////////////////////////////////
    // Controller and pins
    ////////////////////////////////////////

    cic_bus_ctrl u_bus_ctrl (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_req_valid      (ctrl_req_valid),
        .i_req            (ctrl_req),
        .o_req_credit     (ctrl_req_credit),
        .o_rsp_push       (ctrl_rsp_push),
        .o_rsp            (ctrl_rsp),
        .i_rsp_credit     (ctrl_rsp_credit),
        .i_settings       (i_settings),
        .i_pins           (pins),
        .o_dq_we          (dq_we),
        .o_dq_bit         (dq_bit),
        .o_invalid_region (o_invalid_region)
    );

    cic_pin_io u_pin_io (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_n64_reset (i_n64_reset),
        .i_cic_clk   (i_cic_clk),
        .i_cic_dq    (i_cic_dq),
        .i_dq_we     (dq_we),
        .i_dq_bit    (dq_bit),
        .o_pins      (pins),
        .o_cic_dq_oe (o_cic_dq_oe)
    );

endmodule

//--- hw/cic_bus_ctrl.sv
`timescale 1ns/1ps
`include "cic_config.svh"

module cic_bus_ctrl (
    input  logic                   clk,
    input  logic                   i_rst_n,

    // Requests from the request FIFO
    input  logic                   i_req_valid,
    input  cic_pkg::cic_bus_req_t  i_req,
    output logic                   o_req_credit,

    // Responses into the response FIFO
    output logic                   o_rsp_push,
    output cic_pkg::cic_bus_rsp_t  o_rsp,
    input  logic                   i_rsp_credit,

    // Boot settings and lockout pins
    input  cic_pkg::cic_settings_t i_settings,
    input  cic_pkg::cic_pins_t     i_pins,
    output logic                   o_dq_we,
    output logic                   o_dq_bit,
    output logic                   o_invalid_region
);
    import cic_pkg::*;

    localparam logic [1:0] SEL_RAM = 2'b10;
    localparam logic [1:0] SEL_REG = 2'b11;
    localparam int         CW      = $clog2(`CIC_RSP_DEPTH + 1);

    ////////////////////////////////////////
    // Request decode
    ////////////////////////////////////////

    logic [`CIC_RAM_AW-1:0] ram_idx;
    logic                   req_ram;
    logic                   req_reg;
    logic                   pin_write;

    assign ram_idx = i_req.addr[2 +: `CIC_RAM_AW];
    assign req_ram = i_req_valid && (i_req.addr[31:30] == SEL_RAM);
    assign req_reg = i_req_valid && (i_req.addr[31:30] == SEL_REG);

    // Only register 2 has side effects on a write
    assign pin_write = req_reg && i_req.write && (i_req.addr[3:2] == `CIC_REG_PINS);

    ////////////////////////////////////////
    // Firmware RAM
    ////////////////////////////////////////

    logic [31:0] ram [`CIC_RAM_WORDS];
    logic [31:0] ram_q;

    // Reads are registered, so read data is ready one cycle after acceptance
    always_ff @(posedge clk) begin
        if (req_ram) begin
            if (i_req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_req.mask[b]) begin
                        ram[ram_idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
                    end
                end
            end
            ram_q <= ram[ram_idx];
        end
    end

    ////////////////////////////////////////
    // Response stage
    ////////////////////////////////////////

    cic_bus_req_t  s1_req;       // The one request held in the controller
    logic          s1_valid;
    logic [CW-1:0] rsp_credits;
    logic          push_ok;
    logic          started;
    logic [31:0]   reg_rdata;
    cic_bus_rsp_t  rsp_next;

    assign push_ok = s1_valid && (rsp_credits != '0);

    always_comb begin
        case (s1_req.addr[3:2])
            `CIC_REG_SETTINGS: reg_rdata = {
                5'd0,
                i_settings.disabled,
                i_settings.mode_64dd,
                i_settings.region,
                i_settings.seed,
                i_settings.checksum[47:32]
            };
            `CIC_REG_CHECKSUM: reg_rdata = i_settings.checksum[31:0];
            `CIC_REG_PINS:     reg_rdata = {29'd0, i_pins};
            default:           reg_rdata = '0;
        endcase
    end

    always_comb begin
        rsp_next.write = s1_req.write;
        rsp_next.rdata = '0;
        if (!s1_req.write) begin
            case (s1_req.addr[31:30])
                SEL_RAM: rsp_next.rdata = ram_q;
                SEL_REG: rsp_next.rdata = reg_rdata;
                default: rsp_next.rdata = '0;  // Undecoded space
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_req_valid) begin
            s1_req <= i_req;
        end
        if (push_ok) begin
            o_rsp <= rsp_next;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid     <= 1'b0;
            rsp_credits  <= CW'(`CIC_RSP_DEPTH);
            o_rsp_push   <= 1'b0;
            o_req_credit <= 1'b0;
            started      <= 1'b0;
        end else begin
            if (i_req_valid) begin
                s1_valid <= 1'b1;
            end else if (push_ok) begin
                s1_valid <= 1'b0;
            end
            rsp_credits <= rsp_credits + CW'(i_rsp_credit) - CW'(push_ok);
            o_rsp_push  <= push_ok;

            // First grant right after reset, then one per finished request
            o_req_credit <= push_ok || !started;
            started      <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Pin control
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dq_we          <= 1'b0;
            o_dq_bit         <= 1'b1;
            o_invalid_region <= 1'b0;
        end else begin
            o_dq_we          <= pin_write;
            o_invalid_region <= pin_write && i_req.wdata[3];  // Single cycle pulse
            if (pin_write) begin
                o_dq_bit <= i_req.wdata[0];
            end
        end
    end

endmodule

//--- hw/cic_pin_io.sv
`timescale 1ns/1ps

module cic_pin_io (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_n64_reset,
    input  logic               i_cic_clk,
    input  logic               i_cic_dq,
    input  logic               i_dq_we,
    input  logic               i_dq_bit,
    output cic_pkg::cic_pins_t o_pins,
    output logic               o_cic_dq_oe
);
    import cic_pkg::*;

    cic_pins_t pins_meta;   // First flop, may go metastable
    cic_pins_t pins_sync;
    logic      dq_release;  // High leaves the open-drain line floating

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pins_meta <= '0;
            pins_sync <= '0;
        end else begin
            pins_meta <= '{n64_reset: i_n64_reset, cic_clk: i_cic_clk, cic_dq: i_cic_dq};
            pins_sync <= pins_meta;
        end
    end

    // The line stays released for as long as the console holds reset
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dq_release <= 1'b1;
        end else if (!pins_sync.n64_reset) begin
            dq_release <= 1'b1;
        end else if (i_dq_we) begin
            dq_release <= i_dq_bit;
        end
    end

    assign o_cic_dq_oe = !dq_release && pins_sync.n64_reset;  // Release at once on console reset
    assign o_pins      = pins_sync;

endmodule

//--- hw/cic_credit_fifo.sv
`timescale 1ns/1ps

module cic_credit_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic i_rst_n,

    // Upstream side, the sender pushes only against its own credits
    input  logic i_push,
    input  T     i_data,
    output logic o_up_credit,

    // Downstream side
    input  logic i_down_credit,
    output logic o_valid,
    output T     o_data
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam int KW = 16;  // Downstream grants may run ahead of the stored entries

    T              mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [KW-1:0] credits;
    logic          pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // The head leaves whenever one is stored and the receiver holds room for it
    assign pop     = (count != '0) && (credits != '0);
    assign o_valid = pop;
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            credits     <= '0;
            o_up_credit <= 1'b0;
        end else begin
            if (i_push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)    rd_ptr <= next_ptr(rd_ptr);
            count       <= count + CW'(i_push) - CW'(pop);
            credits     <= credits + KW'(i_down_credit) - KW'(pop);
            o_up_credit <= pop;  // One slot freed per entry sent
        end
    end

endmodule

//--- hw/cic_pkg.sv
package cic_pkg;

    ////////////////////////////////////////
    // Firmware data bus
    ////////////////////////////////////////

    // One firmware access, 69 bits
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;   // Byte enables, bit 0 is the low byte
        logic        write;
    } cic_bus_req_t;

    // Reply to one access, 33 bits
    typedef struct packed {
        logic [31:0] rdata;  // Zero for writes
        logic        write;
    } cic_bus_rsp_t;

    ////////////////////////////////////////
    // Boot settings and console pins
    ////////////////////////////////////////

    // Values handed down by the rest of the cartridge, 59 bits
    typedef struct packed {
        logic        disabled;
        logic        mode_64dd;
        logic        region;    // 1 selects PAL
        logic [7:0]  seed;
        logic [47:0] checksum;
    } cic_settings_t;

    // Console lockout pins after synchronization
    // Field order matches the register 2 readback
    typedef struct packed {
        logic n64_reset;
        logic cic_clk;
        logic cic_dq;
    } cic_pins_t;

endpackage

//--- hw/cic_config.svh
`ifndef CIC_CONFIG_SVH
`define CIC_CONFIG_SVH

// Firmware RAM geometry
`define CIC_RAM_WORDS 512
`define CIC_RAM_AW 9

// Entries in each direction of the firmware port
`define CIC_REQ_DEPTH 4
`define CIC_RSP_DEPTH 4

// Register window indices, taken from address bits 3:2
`define CIC_REG_SETTINGS 2'd0
`define CIC_REG_CHECKSUM 2'd1
`define CIC_REG_PINS 2'd2

`endif
